// ==== Makefile ====
# Verilator flow for the buffered OTP partition testbench
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR   ?= verilator
TOP         ?= tb_otp_part_buf
FLIST       ?= vlog.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# A $fatal in the run gives a nonzero exit status
sim:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/otp_part_buf.sv ====
/*
  Buffered OTP partition
  Reads the partition into registers, unlocks it and checks consistency
*/
`timescale 1ns/1ns

module otp_part_buf #(
  parameter int  PartOffset = 64,
  parameter int  NumBlocks  = 4,
  localparam int BW         = otp_part_pkg::BlockWidth
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Init and consistency check
  input  logic                                   init_req_i,
  output logic                                   init_done_o,
  input  logic                                   cnsty_chk_req_i,
  output logic                                   cnsty_chk_ack_o,
  input  logic                                   escalate_en_i,
  input  logic                                   check_byp_en_i,
  output otp_part_pkg::otp_err_e                 error_o,
  output logic                                   fsm_err_o,
  // Access locks
  input  logic                                   read_lock_i,
  input  logic                                   write_lock_i,
  output logic                                   read_lock_o,
  output logic                                   write_lock_o,
  // Buffered data
  output logic [BW-1:0]                          digest_o,
  output logic [NumBlocks*BW-1:0]                data_o,
  // OTP macro
  output logic                                   otp_req_o,
  output logic [otp_part_pkg::OtpSizeWidth-1:0]  otp_size_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0]  otp_addr_o,
  input  logic                                   otp_gnt_i,
  input  logic                                   otp_rvalid_i,
  input  logic [BW-1:0]                          otp_rdata_i,
  input  otp_part_pkg::otp_err_e                 otp_err_i
);

  localparam int CntWidth  = (NumBlocks > 1) ? $clog2(NumBlocks) : 1;
  localparam int SizeWidth = otp_part_pkg::OtpSizeWidth;
  // Halfwords in one block
  localparam int BlkHalfwords = otp_part_pkg::BlockBytes >> otp_part_pkg::OtpAddrShift;

  logic                    cnt_clr, cnt_en, last_blk;
  logic [CntWidth-1:0]     cnt;
  logic                    buf_wren, unlock, lock;
  logic [BW-1:0]           buf_rdata;
  logic [NumBlocks*BW-1:0] buf_data;

  // Every read fetches one whole block
  assign otp_size_o = SizeWidth'(BlkHalfwords - 1);

  part_buf_fsm u_fsm (
    .clk_i, .rst_ni,
    .init_req_i, .cnsty_chk_req_i, .escalate_en_i, .check_byp_en_i,
    .otp_gnt_i, .otp_rvalid_i, .otp_rdata_i, .otp_err_i,
    .last_blk_i  (last_blk),
    .buf_rdata_i (buf_rdata),
    .otp_req_o,
    .cnt_clr_o   (cnt_clr),
    .cnt_en_o    (cnt_en),
    .buf_wren_o  (buf_wren),
    .unlock_o    (unlock),
    .lock_o      (lock),
    .cnsty_chk_ack_o, .error_o, .fsm_err_o
  );

  part_addr_gen #(.PartOffset(PartOffset), .NumBlocks(NumBlocks)) u_addr_gen (
    .clk_i, .rst_ni,
    .cnt_clr_i  (cnt_clr),
    .cnt_en_i   (cnt_en),
    .cnt_o      (cnt),
    .last_blk_o (last_blk),
    .otp_addr_o
  );

  part_buf_regs #(.NumBlocks(NumBlocks)) u_buf_regs (
    .clk_i, .rst_ni,
    .wren_i  (buf_wren),
    .idx_i   (cnt),
    .wdata_i (otp_rdata_i),
    .rdata_o (buf_rdata),
    .data_o  (buf_data)
  );

  part_lock_ctrl #(.NumBlocks(NumBlocks)) u_lock_ctrl (
    .clk_i, .rst_ni,
    .unlock_i (unlock),
    .lock_i   (lock),
    .data_i   (buf_data),
    .read_lock_i, .write_lock_i,
    .init_done_o, .data_o, .digest_o,
    .read_lock_o, .write_lock_o
  );

endmodule

// ==== design/otp_part_pkg.sv ====
/*
  Shared definitions for the buffered OTP partition
  Block and address widths, OTP error codes and partition FSM states
*/
package otp_part_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // One partition block, same as one OTP read beat
  localparam int BlockWidth       = 64;
  localparam int BlockBytes       = BlockWidth / 8;
  // OTP byte address
  localparam int OtpByteAddrWidth = 11;
  // Macro is addressed in 16 bit halfwords
  localparam int OtpAddrShift     = 1;
  localparam int OtpAddrWidth     = OtpByteAddrWidth - OtpAddrShift;
  // Transfer size field, value is halfwords minus one
  localparam int OtpSizeWidth     = 2;

  ////////////////////////////////////////////////////////////
  // Error codes and states
  ////////////////////////////////////////////////////////////

  // Error code as reported by the macro and latched by the partition
  typedef enum logic [2:0] {
    NoError             = 3'd0,
    MacroError          = 3'd1,
    MacroEccCorrError   = 3'd2,
    MacroEccUncorrError = 3'd3,
    CheckFailError      = 3'd4,
    FsmStateError       = 3'd5
  } otp_err_e;

  // Partition control FSM
  typedef enum logic [3:0] {
    ResetSt         = 4'd0,
    InitSt          = 4'd1,
    InitWaitSt      = 4'd2,
    IdleSt          = 4'd3,
    CnstyReadSt     = 4'd4,
    CnstyReadWaitSt = 4'd5,
    ErrorSt         = 4'd6
  } part_state_e;

endpackage

// ==== design/part_addr_gen.sv ====
/*
  Block counter and OTP address generation
  Walks the partition block by block and gives the halfword address
*/
`timescale 1ns/1ns

module part_addr_gen #(
  parameter int  PartOffset = 64,
  parameter int  NumBlocks  = 4,
  localparam int CntWidth   = (NumBlocks > 1) ? $clog2(NumBlocks) : 1
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                cnt_clr_i,
  input  logic                                cnt_en_i,
  output logic [CntWidth-1:0]                 cnt_o,
  output logic                                last_blk_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0] otp_addr_o
);

  localparam int AW = otp_part_pkg::OtpByteAddrWidth;

  logic [CntWidth-1:0] cnt_q;
  logic [AW-1:0]       byte_addr;

  // Block counter, clear has priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_clr_i) begin
      cnt_q <= '0;
    end else if (cnt_en_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Byte offset of the current block
  assign byte_addr = AW'(PartOffset) + AW'(cnt_q) * AW'(otp_part_pkg::BlockBytes);

  // Drop the byte bit, blocks are always halfword aligned
  assign otp_addr_o = byte_addr[AW-1:otp_part_pkg::OtpAddrShift];

  assign cnt_o      = cnt_q;
  assign last_blk_o = (cnt_q == CntWidth'(NumBlocks - 1));

endmodule

// ==== design/part_buf_fsm.sv ====
/*
  Partition control FSM
  Reads the partition into the buffer, runs consistency checks
  and latches OTP and check errors
*/
`timescale 1ns/1ns

module part_buf_fsm (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     init_req_i,
  input  logic                                     cnsty_chk_req_i,
  input  logic                                     escalate_en_i,
  input  logic                                     check_byp_en_i,
  input  logic                                     otp_gnt_i,
  input  logic                                     otp_rvalid_i,
  input  logic [otp_part_pkg::BlockWidth-1:0]      otp_rdata_i,
  input  otp_part_pkg::otp_err_e                   otp_err_i,
  input  logic                                     last_blk_i,
  input  logic [otp_part_pkg::BlockWidth-1:0]      buf_rdata_i,
  output logic                                     otp_req_o,
  output logic                                     cnt_clr_o,
  output logic                                     cnt_en_o,
  output logic                                     buf_wren_o,
  output logic                                     unlock_o,
  output logic                                     lock_o,
  output logic                                     cnsty_chk_ack_o,
  output otp_part_pkg::otp_err_e                   error_o,
  output logic                                     fsm_err_o
);

  otp_part_pkg::part_state_e state_d, state_q;
  otp_part_pkg::otp_err_e    error_d, error_q;
  logic                      resp_ok;
  logic                      blk_match;

  // Only clean or corrected reads are usable
  assign resp_ok   = (otp_err_i == otp_part_pkg::NoError) ||
                     (otp_err_i == otp_part_pkg::MacroEccCorrError);
  assign blk_match = (otp_rdata_i == buf_rdata_i) || check_byp_en_i;

  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    otp_req_o       = 1'b0;
    cnt_clr_o       = 1'b0;
    cnt_en_o        = 1'b0;
    buf_wren_o      = 1'b0;
    unlock_o        = 1'b0;
    lock_o          = 1'b0;
    cnsty_chk_ack_o = 1'b0;
    fsm_err_o       = 1'b0;

    case (state_q)
      // Wait for the one init request after reset
      otp_part_pkg::ResetSt: begin
        if (init_req_i) begin
          cnt_clr_o = 1'b1;
          state_d   = otp_part_pkg::InitSt;
        end
      end
      // Request the current block
      otp_part_pkg::InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = otp_part_pkg::InitWaitSt;
        end
      end
      // Store the block, then next block or unlock
      otp_part_pkg::InitWaitSt: begin
        if (otp_rvalid_i) begin
          if (resp_ok) begin
            buf_wren_o = 1'b1;
            if (last_blk_i) begin
              unlock_o = 1'b1;
              state_d  = otp_part_pkg::IdleSt;
            end else begin
              cnt_en_o = 1'b1;
              state_d  = otp_part_pkg::InitSt;
            end
            if (otp_err_i != otp_part_pkg::NoError) begin
              error_d = otp_part_pkg::MacroEccCorrError;
            end
          end else begin
            error_d = otp_err_i;
            state_d = otp_part_pkg::ErrorSt;
          end
        end
      end
      otp_part_pkg::IdleSt: begin
        if (cnsty_chk_req_i) begin
          cnt_clr_o = 1'b1;
          state_d   = otp_part_pkg::CnstyReadSt;
        end
      end
      // Re-read for the consistency check
      otp_part_pkg::CnstyReadSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = otp_part_pkg::CnstyReadWaitSt;
        end
      end
      // Compare against the buffer, ack on the last block or on failure
      otp_part_pkg::CnstyReadWaitSt: begin
        if (otp_rvalid_i) begin
          if (resp_ok) begin
            if (otp_err_i != otp_part_pkg::NoError) begin
              error_d = otp_part_pkg::MacroEccCorrError;
            end
            if (!blk_match) begin
              error_d         = otp_part_pkg::CheckFailError;
              cnsty_chk_ack_o = 1'b1;
              state_d         = otp_part_pkg::ErrorSt;
            end else if (last_blk_i) begin
              cnsty_chk_ack_o = 1'b1;
              state_d         = otp_part_pkg::IdleSt;
            end else begin
              cnt_en_o = 1'b1;
              state_d  = otp_part_pkg::CnstyReadSt;
            end
          end else begin
            error_d         = otp_err_i;
            cnsty_chk_ack_o = 1'b1;
            state_d         = otp_part_pkg::ErrorSt;
          end
        end
      end
      // Terminal state, partition stays locked and checks ack at once
      otp_part_pkg::ErrorSt: begin
        lock_o          = 1'b1;
        cnsty_chk_ack_o = 1'b1;
        if (error_q == otp_part_pkg::NoError) begin
          error_d = otp_part_pkg::FsmStateError;
        end
      end
      // Invalid encoding
      default: begin
        fsm_err_o = 1'b1;
        error_d   = otp_part_pkg::FsmStateError;
        state_d   = otp_part_pkg::ErrorSt;
      end
    endcase

    // Escalation overrides everything
    if (escalate_en_i) begin
      fsm_err_o = 1'b1;
      state_d   = otp_part_pkg::ErrorSt;
      if (state_q != otp_part_pkg::ErrorSt) begin
        error_d = otp_part_pkg::FsmStateError;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= otp_part_pkg::ResetSt;
      error_q <= otp_part_pkg::NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

  assign error_o = error_q;

endmodule

// ==== design/part_buf_regs.sv ====
/*
  Partition buffer registers
  One 64 bit register per block, written from OTP read data
  Block at the current index is read back for the consistency compare
*/
`timescale 1ns/1ns

module part_buf_regs #(
  parameter int  NumBlocks = 4,
  localparam int CntWidth  = (NumBlocks > 1) ? $clog2(NumBlocks) : 1,
  localparam int BW        = otp_part_pkg::BlockWidth
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    wren_i,
  input  logic [CntWidth-1:0]     idx_i,
  input  logic [BW-1:0]           wdata_i,
  output logic [BW-1:0]           rdata_o,
  output logic [NumBlocks*BW-1:0] data_o
);

  logic [BW-1:0] blk_q [NumBlocks];

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Buffer starts out blank so the digest reads as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      blk_q <= '{default: '0};
    end else if (wren_i) begin
      blk_q[idx_i] <= wdata_i;
    end
  end

  // Readback of the block being compared
  assign rdata_o = blk_q[idx_i];

  ////////////////////////////////////////////////////////////
  // Flattened view
  ////////////////////////////////////////////////////////////

  // Block 0 sits in the low bits, digest at the top
  for (genvar g = 0; g < NumBlocks; g++) begin : gen_flat
    assign data_o[g*BW +: BW] = blk_q[g];
  end

endmodule

// ==== design/part_lock_ctrl.sv ====
/*
  Partition lock control
  Holds the data lock, gates the buffered data and registers the
  read and write locks for the direct access port
*/
`timescale 1ns/1ns

module part_lock_ctrl #(
  parameter int  NumBlocks = 4,
  localparam int BW        = otp_part_pkg::BlockWidth
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    unlock_i,
  input  logic                    lock_i,
  input  logic [NumBlocks*BW-1:0] data_i,
  input  logic                    read_lock_i,
  input  logic                    write_lock_i,
  output logic                    init_done_o,
  output logic [NumBlocks*BW-1:0] data_o,
  output logic [BW-1:0]           digest_o,
  output logic                    read_lock_o,
  output logic                    write_lock_o
);

  logic locked_d, locked_q;
  logic rd_lock_q, wr_lock_q;
  logic digest_set;

  // Lock request wins over unlock
  always_comb begin
    locked_d = locked_q;
    if (unlock_i) begin
      locked_d = 1'b0;
    end
    if (lock_i) begin
      locked_d = 1'b1;
    end
  end

  // Digest is the last block, never gated
  assign digest_o   = data_i[NumBlocks*BW-1 -: BW];
  assign digest_set = |digest_o;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  // Access locks take the next lock value so they never lag the data lock
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      locked_q  <= 1'b1;
      rd_lock_q <= 1'b1;
      wr_lock_q <= 1'b1;
    end else begin
      locked_q  <= locked_d;
      rd_lock_q <= locked_d | read_lock_i;
      // A programmed digest freezes the partition
      wr_lock_q <= locked_d | write_lock_i | digest_set;
    end
  end

  // Partition counts as initialized once unlocked
  assign init_done_o  = ~locked_q;
  assign data_o       = locked_q ? '0 : data_i;
  assign read_lock_o  = rd_lock_q;
  assign write_lock_o = wr_lock_q;

endmodule

// ==== verif/otp_macro_model.sv ====
/*
  Behavioral OTP macro
  Grants a read, returns one 64 bit block a few cycles later and
  can inject one error code on a chosen block
*/
`timescale 1ns/1ns

module otp_macro_model #(
  parameter int GntDelay = 1,
  parameter int RdDelay  = 2,
  parameter int Words    = 256
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_i,
  input  logic [otp_part_pkg::OtpAddrWidth-1:0] addr_i,
  output logic                                  gnt_o,
  output logic                                  rvalid_o,
  output logic [otp_part_pkg::BlockWidth-1:0]   rdata_o,
  output otp_part_pkg::otp_err_e                err_o,
  // One shot error injection
  input  logic                                  inj_en_i,
  input  logic [7:0]                            inj_blk_i,
  input  otp_part_pkg::otp_err_e                inj_err_i
);

  typedef enum logic [1:0] {
    Idle,
    Grant,
    Data
  } phase_e;

  // Storage in whole blocks, loaded by the testbench
  logic [otp_part_pkg::BlockWidth-1:0] mem [Words];
  phase_e                              phase_q;
  int                                  dly_q;
  logic [7:0]                          blk_q;
  logic                                inj_done_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o      <= 1'b0;
      rvalid_o   <= 1'b0;
      rdata_o    <= '0;
      err_o      <= otp_part_pkg::NoError;
      phase_q    <= Idle;
      dly_q      <= 0;
      blk_q      <= '0;
      inj_done_q <= 1'b0;
    end else begin
      // Grant and rvalid are single cycle strobes
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      case (phase_q)
        Idle: begin
          if (req_i) begin
            phase_q <= Grant;
            dly_q   <= GntDelay;
          end
        end
        Grant: begin
          if (dly_q > 0) begin
            dly_q <= dly_q - 1;
          end else begin
            gnt_o   <= 1'b1;
            // Four halfwords per block
            blk_q   <= addr_i[otp_part_pkg::OtpAddrWidth-1:2];
            phase_q <= Data;
            dly_q   <= RdDelay;
          end
        end
        default: begin
          if (dly_q > 0) begin
            dly_q <= dly_q - 1;
          end else begin
            rvalid_o <= 1'b1;
            rdata_o  <= mem[blk_q];
            err_o    <= otp_part_pkg::NoError;
            if (inj_en_i && !inj_done_q && (blk_q == inj_blk_i)) begin
              err_o      <= inj_err_i;
              inj_done_q <= 1'b1;
            end
            phase_q <= Idle;
          end
        end
      endcase
    end
  end

endmodule

// ==== verif/otp_part_buf_properties.sv ====
/*
  Bound checks on the partition top level
  Reset behavior, lock coupling and ack versus OTP request
*/
`timescale 1ns/1ns

module otp_part_buf_properties (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      otp_req_o,
  input logic                      init_done_o,
  input logic                      read_lock_o,
  input logic                      write_lock_o,
  input logic                      cnsty_chk_ack_o,
  input otp_part_pkg::part_state_e state_i
);

  // First cycle out of reset issues no read
  req_after_reset_a: assert property (@(posedge clk_i) $rose(rst_ni) |-> !otp_req_o)
    else $error("OTP request in the first cycle after reset");

  // Partition stays closed to direct access until initialized
  locks_before_init_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !init_done_o |-> (read_lock_o && write_lock_o))
    else $error("Access lock low while init_done_o is low");

  // Ack ends a check, so no read can be pending with it
  ack_vs_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i != otp_part_pkg::ErrorSt) |-> !(cnsty_chk_ack_o && otp_req_o))
    else $error("Check ack together with OTP request outside the error state");

endmodule

bind otp_part_buf otp_part_buf_properties u_props (
  .clk_i,
  .rst_ni,
  .otp_req_o,
  .init_done_o,
  .read_lock_o,
  .write_lock_o,
  .cnsty_chk_ack_o,
  .state_i (u_fsm.state_q)
);

// ==== verif/tb_clk_gen.sv ====
/*
  Testbench clock and reset
  Free running clock, reset held low for a few cycles at start and on request
*/
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PeriodNs  = 20,
  parameter int RstCycles = 2
) (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_no
);

  // Reset cycles still to go, reset is active from time zero
  int unsigned rst_cnt = RstCycles;

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // A request restarts the reset pulse
  always @(posedge clk_o) begin
    if (rst_req_i) begin
      rst_cnt <= RstCycles;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  assign rst_no = (rst_cnt == 0);

endmodule

// ==== verif/tb_otp_part_buf.sv ====
/*
  Testbench for the buffered OTP partition
  Runs a table of init, check and escalation cases against a macro model
*/
`timescale 1ns/1ns

module tb_otp_part_buf;

  localparam int PartOffset = 64;
  localparam int NumBlocks  = 4;
  localparam int BW         = otp_part_pkg::BlockWidth;
  localparam int DW         = NumBlocks * BW;
  localparam int MemBlocks  = 256;
  localparam int PartBlk0   = PartOffset / otp_part_pkg::BlockBytes;
  localparam int DigestBlk  = PartBlk0 + NumBlocks - 1;
  localparam int NumCases   = 7;
  localparam int Timeout    = 200;

  typedef logic [DW-1:0] cmp_t;
  typedef enum logic [1:0] {CaseInit, CaseCheck, CaseEscalate} case_kind_e;
  typedef enum logic [2:0] {WaitRst, WaitDone, WaitNotDone, WaitErr, WaitAck} wait_e;

  // One row of the case table
  typedef struct packed {
    case_kind_e             kind;
    logic                   inj_en;
    logic [1:0]             inj_blk;
    otp_part_pkg::otp_err_e inj_err;
    logic                   corrupt;
    logic                   byp;
    otp_part_pkg::otp_err_e exp_err;
    logic                   exp_done;
    logic                   exp_zero;
  } case_t;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  rst_req;
  logic                                  init_req;
  logic                                  init_done;
  logic                                  chk_req;
  logic                                  chk_ack;
  logic                                  escalate;
  logic                                  check_byp;
  logic                                  fsm_err;
  logic                                  read_lock_in;
  logic                                  write_lock_in;
  logic                                  read_lock;
  logic                                  write_lock;
  otp_part_pkg::otp_err_e                error;
  otp_part_pkg::otp_err_e                otp_err;
  logic [BW-1:0]                         digest;
  logic [BW-1:0]                         otp_rdata;
  logic [DW-1:0]                         data;
  logic                                  otp_req;
  logic                                  otp_gnt;
  logic                                  otp_rvalid;
  logic [otp_part_pkg::OtpSizeWidth-1:0] otp_size;
  logic [otp_part_pkg::OtpAddrWidth-1:0] otp_addr;
  logic                                  inj_en;
  logic [7:0]                            inj_blk;
  otp_part_pkg::otp_err_e                inj_err;

  case_t         cases [NumCases];
  logic [BW-1:0] ref_mem [MemBlocks];
  logic [15:0]   lfsr_q;
  cmp_t          exp_data;

  tb_clk_gen u_clk_gen (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .rst_no    (rst_n)
  );

  otp_macro_model u_otp (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .req_i     (otp_req),
    .addr_i    (otp_addr),
    .gnt_o     (otp_gnt),
    .rvalid_o  (otp_rvalid),
    .rdata_o   (otp_rdata),
    .err_o     (otp_err),
    .inj_en_i  (inj_en),
    .inj_blk_i (inj_blk),
    .inj_err_i (inj_err)
  );

  otp_part_buf uut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .init_req_i      (init_req),
    .init_done_o     (init_done),
    .cnsty_chk_req_i (chk_req),
    .cnsty_chk_ack_o (chk_ack),
    .escalate_en_i   (escalate),
    .check_byp_en_i  (check_byp),
    .error_o         (error),
    .fsm_err_o       (fsm_err),
    .read_lock_i     (read_lock_in),
    .write_lock_i    (write_lock_in),
    .read_lock_o     (read_lock),
    .write_lock_o    (write_lock),
    .digest_o        (digest),
    .data_o          (data),
    .otp_req_o       (otp_req),
    .otp_size_o      (otp_size),
    .otp_addr_o      (otp_addr),
    .otp_gnt_i       (otp_gnt),
    .otp_rvalid_i    (otp_rvalid),
    .otp_rdata_i     (otp_rdata),
    .otp_err_i       (otp_err)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Reference memory with one LFSR step per bit
  task automatic fill_ref();
    lfsr_q = 16'd10;
    for (int w = 0; w < MemBlocks; w++) begin
      for (int b = 0; b < BW; b++) begin
        lfsr_q        = lfsr_next(lfsr_q);
        ref_mem[w][b] = lfsr_q[0];
      end
    end
    // Block 0 of the partition in the low bits
    for (int k = 0; k < NumBlocks; k++) begin
      exp_data[k*BW +: BW] = ref_mem[PartBlk0 + k];
    end
  endtask

  task automatic check_equal(input cmp_t actual, input cmp_t expected, input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1, "Stopping on the first mismatch");
    end
  endtask

  function automatic logic cond_met(input wait_e sel, input otp_part_pkg::otp_err_e err);
    case (sel)
      WaitRst:     return rst_n;
      WaitDone:    return init_done;
      WaitNotDone: return !init_done;
      WaitErr:     return error == err;
      default:     return chk_ack;
    endcase
  endfunction

  // Sample on the falling edge and give up after Timeout cycles
  task automatic wait_until(input wait_e sel, input otp_part_pkg::otp_err_e err,
                            input string what);
    int n;
    for (n = 0; n < Timeout; n++) begin
      @(negedge clk);
      if (cond_met(sel, err)) begin
        break;
      end
    end
    if (n == Timeout) begin
      $display("Timed out after %0d cycles waiting for %s", Timeout, what);
      $display("Test failures found");
      $fatal(1, "Wait timed out");
    end
  endtask

  task automatic reset_dut();
    @(posedge clk);
    rst_req <= 1'b1;
    @(posedge clk);
    rst_req <= 1'b0;
    @(negedge clk);
    // Outputs while reset is held
    check_equal(cmp_t'(rst_n), cmp_t'(1'b0), "reset asserted");
    check_equal(cmp_t'({otp_req, chk_ack, init_done, fsm_err}), '0, "control in reset");
    check_equal(cmp_t'(error), cmp_t'(otp_part_pkg::NoError), "error_o in reset");
    check_equal(cmp_t'({read_lock, write_lock}), cmp_t'(2'b11), "locks in reset");
    check_equal(data, '0, "data_o in reset");
    wait_until(WaitRst, otp_part_pkg::NoError, "reset release");
  endtask

  ////////////////////////////////////////////////////////////
  // One row of the table
  ////////////////////////////////////////////////////////////

  task automatic run_case(input int idx, input case_t c);
    string tag;
    int    ack_cnt;
    tag = $sformatf("case %0d", idx);
    @(posedge clk);
    init_req      <= 1'b0;
    chk_req       <= 1'b0;
    escalate      <= 1'b0;
    check_byp     <= 1'b0;
    read_lock_in  <= 1'b0;
    write_lock_in <= 1'b0;
    inj_en        <= c.inj_en;
    inj_blk       <= 8'(PartBlk0) + 8'(c.inj_blk);
    inj_err       <= c.inj_err;
    // Undo any corruption from an earlier row
    for (int w = 0; w < MemBlocks; w++) begin
      u_otp.mem[w] = ref_mem[w];
    end
    reset_dut();

    @(posedge clk);
    init_req <= 1'b1;
    @(posedge clk);
    init_req <= 1'b0;
    if (c.kind == CaseInit && !c.exp_done) begin
      wait_until(WaitErr, c.exp_err, {tag, " init error"});
    end else begin
      wait_until(WaitDone, otp_part_pkg::NoError, {tag, " init done"});
      check_equal(data, exp_data, {tag, " data after init"});
      check_equal(cmp_t'(digest), cmp_t'(ref_mem[DigestBlk]), {tag, " digest_o"});
      check_equal(cmp_t'(otp_size), cmp_t'(3), {tag, " transfer size"});
      check_equal(cmp_t'(read_lock), cmp_t'(1'b0), {tag, " read lock"});
      // Digest lands with the unlock, the registered write lock sees it a cycle later
      @(negedge clk);
      // Nonzero digest write locks the partition
      check_equal(cmp_t'(write_lock), cmp_t'(ref_mem[DigestBlk] != '0),
                  {tag, " write lock"});
    end

    // Read lock follows its input one cycle later
    if (c.kind == CaseInit && c.exp_done) begin
      @(posedge clk);
      read_lock_in <= 1'b1;
      @(negedge clk);
      check_equal(cmp_t'(read_lock), cmp_t'(1'b0), {tag, " read lock before"});
      @(negedge clk);
      check_equal(cmp_t'(read_lock), cmp_t'(1'b1), {tag, " read lock after"});
    end

    if (c.kind == CaseCheck) begin
      if (c.corrupt) begin
        u_otp.mem[PartBlk0 + 1] = ~ref_mem[PartBlk0 + 1];
      end
      @(posedge clk);
      check_byp <= c.byp;
      chk_req   <= 1'b1;
      @(posedge clk);
      chk_req <= 1'b0;
      wait_until(WaitAck, otp_part_pkg::NoError, {tag, " check ack"});
      ack_cnt = 1;
      // A passing check acks once and goes back to idle
      if (c.exp_done) begin
        repeat (8) begin
          @(negedge clk);
          if (chk_ack) begin
            ack_cnt++;
          end
        end
        check_equal(cmp_t'(ack_cnt), cmp_t'(1), {tag, " ack count"});
      end
    end

    if (c.kind == CaseEscalate) begin
      @(posedge clk);
      escalate <= 1'b1;
      @(negedge clk);
      check_equal(cmp_t'(fsm_err), cmp_t'(1'b1), {tag, " fsm_err_o"});
    end

    // Final state of the row
    wait_until(c.exp_done ? WaitDone : WaitNotDone, otp_part_pkg::NoError, {tag, " done level"});
    check_equal(cmp_t'(error), cmp_t'(c.exp_err), {tag, " error_o"});
    check_equal(cmp_t'(init_done), cmp_t'(c.exp_done), {tag, " init_done_o"});
    check_equal(cmp_t'(data == '0), cmp_t'(c.exp_zero), {tag, " data_o zero flag"});
    if (!c.exp_zero) begin
      check_equal(data, exp_data, {tag, " data_o"});
    end
    if (!c.exp_done) begin
      check_equal(cmp_t'({read_lock, write_lock}), cmp_t'(2'b11), {tag, " locks"});
    end
  endtask

  initial begin
    rst_req       = 1'b0;
    init_req      = 1'b0;
    chk_req       = 1'b0;
    escalate      = 1'b0;
    check_byp     = 1'b0;
    read_lock_in  = 1'b0;
    write_lock_in = 1'b0;
    inj_en        = 1'b0;
    inj_blk       = '0;
    inj_err       = otp_part_pkg::NoError;

    // kind, inj, blk, inj err, corrupt, bypass, exp err, done, zero
    cases[0] = '{CaseInit, 1'b0, 2'd0, otp_part_pkg::NoError, 1'b0, 1'b0,
                 otp_part_pkg::NoError, 1'b1, 1'b0};
    cases[1] = '{CaseCheck, 1'b0, 2'd0, otp_part_pkg::NoError, 1'b0, 1'b0,
                 otp_part_pkg::NoError, 1'b1, 1'b0};
    cases[2] = '{CaseInit, 1'b1, 2'd1, otp_part_pkg::MacroEccCorrError, 1'b0, 1'b0,
                 otp_part_pkg::MacroEccCorrError, 1'b1, 1'b0};
    cases[3] = '{CaseCheck, 1'b0, 2'd0, otp_part_pkg::NoError, 1'b1, 1'b0,
                 otp_part_pkg::CheckFailError, 1'b0, 1'b1};
    cases[4] = '{CaseCheck, 1'b0, 2'd0, otp_part_pkg::NoError, 1'b1, 1'b1,
                 otp_part_pkg::NoError, 1'b1, 1'b0};
    cases[5] = '{CaseInit, 1'b1, 2'd2, otp_part_pkg::MacroEccUncorrError, 1'b0, 1'b0,
                 otp_part_pkg::MacroEccUncorrError, 1'b0, 1'b1};
    cases[6] = '{CaseEscalate, 1'b0, 2'd0, otp_part_pkg::NoError, 1'b0, 1'b0,
                 otp_part_pkg::FsmStateError, 1'b0, 1'b1};

    fill_ref();
    for (int i = 0; i < NumCases; i++) begin
      run_case(i, cases[i]);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/otp_part_pkg.sv
design/part_addr_gen.sv
design/part_buf_regs.sv
design/part_lock_ctrl.sv
design/part_buf_fsm.sv
design/otp_part_buf.sv
verif/tb_clk_gen.sv
verif/otp_macro_model.sv
verif/otp_part_buf_properties.sv
verif/tb_otp_part_buf.sv
